// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_commit_stage
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/commit_pkg.sv
rob/rob.sv
hw/head_spill_cell.sv
hw/commit_ctrl.sv
hw/trap_vector.sv
hw/commit_stage.sv
test/tb_commit_stage.sv

// ==== common/commit_defines.svh ====
// Sizing macros for the commit stage, the reorder buffer and the trap logic

`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// ------------------------------
// Datapath
// ------------------------------

// Data and address width
`define XLEN 32

// ------------------------------
// Reorder buffer
// ------------------------------

// ROB slot count kept to a power of two so the pointers wrap naturally
`define ROB_DEPTH 8
`define ROB_IDX_LEN 3

// Architectural register index and exception cause widths
`define REG_IDX_LEN 5
`define EXCEPT_CODE_LEN 4

`endif

// ==== common/commit_pkg.sv ====
// Shared types for the reorder buffer, the commit controller and the trap unit

`include "commit_defines.svh"

package commit_pkg;

  typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;
  typedef logic [`REG_IDX_LEN-1:0] reg_idx_t;
  typedef logic [`EXCEPT_CODE_LEN-1:0] except_code_t;

  // Allocation request from issue
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    reg_idx_t         rd_idx;
  } issue_entry_t;

  // One result on the common data bus
  typedef struct packed {
    rob_idx_t         rob_idx;
    logic [`XLEN-1:0] value;
    logic             except;
    except_code_t     except_code;
    logic             mispredict;
  } cdb_t;

  // One ROB slot
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    reg_idx_t         rd_idx;
    logic [`XLEN-1:0] value;
    logic             res_ready;
    logic             except;
    except_code_t     except_code;
    logic             mispredict;
  } rob_entry_t;

  // Oldest entry leaving the ROB together with its slot
  typedef struct packed {
    rob_entry_t entry;
    rob_idx_t   rob_idx;
  } head_t;

  // Trap vector register with mode 0 direct and mode 1 vectored
  typedef struct packed {
    logic [`XLEN-3:0] base;
    logic [1:0]       mode;
  } mtvec_t;

endpackage

// ==== hw/commit_ctrl.sv ====
// Commit controller that holds the retiring instruction and drives RF writes and flushes

`include "commit_defines.svh"

module commit_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // From the spill cell
  input  logic                     valid_i,
  input  commit_pkg::head_t        data_i,
  output logic                     ready_o,

  // Flush of the ROB and the spill cell
  output logic                     flush_o,

  // Integer register file write
  output logic                     rf_we_o,
  output commit_pkg::reg_idx_t     rf_rd_idx_o,
  output logic [`XLEN-1:0]         rf_rd_value_o,

  // Redirect requests
  output logic                     mis_flush_o,
  output logic                     trap_o,
  output commit_pkg::except_code_t trap_code_o
);

  import commit_pkg::*;

  // RUN retires one instruction per cycle
  // FLUSH holds a flushing instruction for its single pulse cycle
  typedef enum logic {
    RUN,
    FLUSH
  } state_t;

  state_t state_q;
  state_t state_d;

  logic   accept;
  logic   flushing_in;
  logic   comm_valid_q;
  head_t  comm_q;

  // ------------------------------
  // Next state
  // ------------------------------

  assign accept      = valid_i && ready_o;
  assign flushing_in = data_i.entry.except || data_i.entry.mispredict;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (accept && flushing_in) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= RUN;
      comm_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      comm_valid_q <= accept;
    end
  end

  // Commit register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      comm_q <= data_i;
    end
  end

  // ------------------------------
  // Moore outputs
  // ------------------------------

  // No new instruction while the flush is on its way
  assign ready_o = (state_q == RUN);
  assign flush_o = (state_q == FLUSH);

  // x0 is never written, and neither is a trapping instruction
  assign rf_we_o       = comm_valid_q && !comm_q.entry.except && (comm_q.entry.rd_idx != '0);
  assign rf_rd_idx_o   = comm_q.entry.rd_idx;
  assign rf_rd_value_o = comm_q.entry.value;

  // An exception takes priority over a misprediction
  assign trap_o      = (state_q == FLUSH) && comm_q.entry.except;
  assign mis_flush_o = (state_q == FLUSH) && !comm_q.entry.except && comm_q.entry.mispredict;
  assign trap_code_o = comm_q.entry.except_code;

endmodule

// ==== hw/commit_stage.sv ====
// Commit stage top level joining the ROB, head spill cell, commit controller and trap redirect

`include "commit_defines.svh"

module commit_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Issue side
  input  logic                     issue_valid_i,
  input  commit_pkg::issue_entry_t issue_entry_i,
  output logic                     issue_ready_o,
  output commit_pkg::rob_idx_t     issue_tail_idx_o,

  // Result bus
  input  logic                     cdb_valid_i,
  input  commit_pkg::cdb_t         cdb_data_i,

  // Trap vector CSR
  input  commit_pkg::mtvec_t       csr_mtvec_i,

  // Register file and front end
  output logic                     rf_we_o,
  output commit_pkg::reg_idx_t     rf_rd_idx_o,
  output logic [`XLEN-1:0]         rf_rd_value_o,
  output logic                     except_o,
  output logic [`XLEN-1:0]         except_pc_o,
  output logic                     mis_flush_o
);

  import commit_pkg::*;

  // ROB to spill cell
  logic         rob_head_valid;
  head_t        rob_head;
  logic         spill_ready;

  // Spill cell to controller
  logic         spill_valid;
  head_t        spill_data;
  logic         ctrl_ready;

  // Controller outputs
  logic         flush;
  logic         trap;
  except_code_t trap_code;

  rob u_rob (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush),
    .issue_valid_i   (issue_valid_i),
    .issue_entry_i   (issue_entry_i),
    .issue_ready_o   (issue_ready_o),
    .issue_tail_idx_o(issue_tail_idx_o),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_data_i      (cdb_data_i),
    .head_ready_i    (spill_ready),
    .head_valid_o    (rob_head_valid),
    .head_o          (rob_head)
  );

  head_spill_cell u_head_spill_cell (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush),
    .valid_i(rob_head_valid),
    .data_i (rob_head),
    .ready_o(spill_ready),
    .ready_i(ctrl_ready),
    .valid_o(spill_valid),
    .data_o (spill_data)
  );

  commit_ctrl u_commit_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (spill_valid),
    .data_i       (spill_data),
    .ready_o      (ctrl_ready),
    .flush_o      (flush),
    .rf_we_o      (rf_we_o),
    .rf_rd_idx_o  (rf_rd_idx_o),
    .rf_rd_value_o(rf_rd_value_o),
    .mis_flush_o  (mis_flush_o),
    .trap_o       (trap),
    .trap_code_o  (trap_code)
  );

  trap_vector u_trap_vector (
    .trap_i     (trap),
    .trap_code_i(trap_code),
    .csr_mtvec_i(csr_mtvec_i),
    .except_o   (except_o),
    .except_pc_o(except_pc_o)
  );

endmodule

// ==== hw/head_spill_cell.sv ====
// Two-entry skid buffer that registers the ROB head before the commit controller

module head_spill_cell (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,

  // From the ROB
  input  logic              valid_i,
  input  commit_pkg::head_t data_i,
  output logic              ready_o,

  // To the commit controller
  input  logic              ready_i,
  output logic              valid_o,
  output commit_pkg::head_t data_o
);

  import commit_pkg::*;

  logic  out_valid_q;
  head_t out_data_q;
  logic  skid_valid_q;
  head_t skid_data_q;
  logic  out_free;

  // Output slot can load when empty or being drained this cycle
  assign out_free = !out_valid_q || ready_i;

  // Ready depends on registered state only
  assign ready_o = !skid_valid_q;
  assign valid_o = out_valid_q;
  assign data_o  = out_data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (flush_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // Skid slot drains first, otherwise the input passes straight through
      if (skid_valid_q) begin
        out_valid_q  <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        out_valid_q <= valid_i;
      end
    end else if (valid_i && !skid_valid_q) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      out_data_q <= skid_valid_q ? skid_data_q : data_i;
    end
    if (!out_free && !skid_valid_q) begin
      skid_data_q <= data_i;
    end
  end

endmodule

// ==== hw/trap_vector.sv ====
// Trap target computation from mtvec and the front-end redirect outputs

`include "commit_defines.svh"

module trap_vector (
  input  logic                     trap_i,
  input  commit_pkg::except_code_t trap_code_i,
  input  commit_pkg::mtvec_t       csr_mtvec_i,
  output logic                     except_o,
  output logic [`XLEN-1:0]         except_pc_o
);

  import commit_pkg::*;

  logic [`XLEN-1:0] vec_offset;
  logic [`XLEN-1:0] trap_pc;

  // Vectored mode jumps 4 bytes per cause past the base
  assign vec_offset = (csr_mtvec_i.mode == 2'd1) ?
      {{(`XLEN - `EXCEPT_CODE_LEN - 2){1'b0}}, trap_code_i, 2'b00} : '0;

  // Base field is word aligned
  assign trap_pc = {csr_mtvec_i.base, 2'b00} + vec_offset;

  assign except_o    = trap_i;
  assign except_pc_o = trap_i ? trap_pc : '0;

endmodule

// ==== rob/rob.sv ====
// Reorder buffer with in-order allocation, out-of-order CDB completion and the head sent to commit

`include "commit_defines.svh"

module rob (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,

  // Issue side
  input  logic                     issue_valid_i,
  input  commit_pkg::issue_entry_t issue_entry_i,
  output logic                     issue_ready_o,
  output commit_pkg::rob_idx_t     issue_tail_idx_o,

  // Result bus
  input  logic                     cdb_valid_i,
  input  commit_pkg::cdb_t         cdb_data_i,

  // Head towards commit
  input  logic                     head_ready_i,
  output logic                     head_valid_o,
  output commit_pkg::head_t        head_o
);

  import commit_pkg::*;

  localparam int unsigned CNT_LEN = `ROB_IDX_LEN + 1;

  // ------------------------------
  // Storage and pointers
  // ------------------------------

  rob_entry_t            rob_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] valid_q;
  rob_idx_t              head_q;
  rob_idx_t              tail_q;
  logic [CNT_LEN-1:0]    count_q;

  logic                  push;
  logic                  pop;
  logic                  cdb_hit;

  // Full when every slot is allocated
  assign issue_ready_o    = (count_q != CNT_LEN'(`ROB_DEPTH));
  assign issue_tail_idx_o = tail_q;

  assign push = issue_valid_i && issue_ready_o;
  assign pop  = head_valid_o && head_ready_i;

  // Only allocated slots accept a result
  assign cdb_hit = cdb_valid_i && valid_q[cdb_data_i.rob_idx];

  // ------------------------------
  // Head output
  // ------------------------------

  // Head is offered once its result has been written back
  assign head_valid_o  = valid_q[head_q] && rob_q[head_q].res_ready;
  assign head_o.entry   = rob_q[head_q];
  assign head_o.rob_idx = head_q;

  // ------------------------------
  // Control state
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else if (flush_i) begin
      // Everything in flight is younger than the flushing instruction
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else begin
      if (push) begin
        tail_q          <= tail_q + 1'b1;
        valid_q[tail_q] <= 1'b1;
      end
      if (pop) begin
        head_q          <= head_q + 1'b1;
        valid_q[head_q] <= 1'b0;
      end
      count_q <= count_q + CNT_LEN'(push) - CNT_LEN'(pop);
    end
  end

  // ------------------------------
  // Slot payload
  // ------------------------------

  always_ff @(posedge clk_i) begin
    // New entry starts incomplete
    if (push) begin
      rob_q[tail_q].pc          <= issue_entry_i.pc;
      rob_q[tail_q].rd_idx      <= issue_entry_i.rd_idx;
      rob_q[tail_q].value       <= '0;
      rob_q[tail_q].res_ready   <= 1'b0;
      rob_q[tail_q].except      <= 1'b0;
      rob_q[tail_q].except_code <= '0;
      rob_q[tail_q].mispredict  <= 1'b0;
    end
    // Writeback completes the addressed slot
    if (cdb_hit) begin
      rob_q[cdb_data_i.rob_idx].value       <= cdb_data_i.value;
      rob_q[cdb_data_i.rob_idx].except      <= cdb_data_i.except;
      rob_q[cdb_data_i.rob_idx].except_code <= cdb_data_i.except_code;
      rob_q[cdb_data_i.rob_idx].mispredict  <= cdb_data_i.mispredict;
      rob_q[cdb_data_i.rob_idx].res_ready   <= 1'b1;
    end
  end

endmodule

// ==== test/tb_commit_stage.sv ====
// Directed testbench for the commit stage covering allocation, writeback, retirement and flushes

`include "commit_defines.svh"

module tb_commit_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import commit_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int QUIET_CYCLES   = 12;

  localparam logic [1:0] EV_WRITE = 2'd1;
  localparam logic [1:0] EV_TRAP  = 2'd2;
  localparam logic [1:0] EV_MIS   = 2'd3;

  // One observed or expected retirement event
  typedef struct packed {
    logic [1:0]       kind;
    reg_idx_t         rd_idx;
    logic [`XLEN-1:0] value;
  } retire_evt_t;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic             issue_valid_i;
  issue_entry_t     issue_entry_i;
  logic             issue_ready_o;
  rob_idx_t         issue_tail_idx_o;
  logic             cdb_valid_i;
  cdb_t             cdb_data_i;
  mtvec_t           csr_mtvec_i;
  logic             rf_we_o;
  reg_idx_t         rf_rd_idx_o;
  logic [`XLEN-1:0] rf_rd_value_o;
  logic             except_o;
  logic [`XLEN-1:0] except_pc_o;
  logic             mis_flush_o;

  retire_evt_t      seen_q[$];
  retire_evt_t      exp_q[$];
  integer           seed = 32'ha80e_2250;

  commit_stage commit_stage_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic retire_evt_t make_evt(input logic [1:0] kind, input reg_idx_t rd,
                                           input logic [`XLEN-1:0] value);
    retire_evt_t evt;
    evt.kind   = kind;
    evt.rd_idx = rd;
    evt.value  = value;
    return evt;
  endfunction

  // ------------------------------
  // Monitor
  // ------------------------------

  // Outputs are sampled at the edge, where they hold the previous cycle's value
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (rf_we_o) seen_q.push_back(make_evt(EV_WRITE, rf_rd_idx_o, rf_rd_value_o));
      if (except_o) seen_q.push_back(make_evt(EV_TRAP, '0, except_pc_o));
      if (mis_flush_o) seen_q.push_back(make_evt(EV_MIS, '0, '0));
    end
  end

  // ------------------------------
  // Checks and waits
  // ------------------------------

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic wait_retirements(input int n);
    int cycles;
    cycles = 0;
    while (seen_q.size() < n) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("timeout: only %0d of %0d retirement events arrived", seen_q.size(), n);
        $display("sim failed");
        $fatal(1, "retirement never completed");
      end else begin
        @(negedge clk_i);
        cycles++;
      end
    end
    // Idle stretch so that late stray retirements still show up
    repeat (QUIET_CYCLES) @(negedge clk_i);
  endtask

  task automatic match_events();
    check_value("retire event count", seen_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      check_value("retire event kind", seen_q[i].kind, exp_q[i].kind);
      if (exp_q[i].kind == EV_WRITE) begin
        check_value("rf_rd_idx_o", seen_q[i].rd_idx, exp_q[i].rd_idx);
        check_value("rf_rd_value_o", seen_q[i].value, exp_q[i].value);
      end else if (exp_q[i].kind == EV_TRAP) begin
        check_value("except_pc_o", seen_q[i].value, exp_q[i].value);
      end
    end
  endtask

  // Expected writes skip x0
  task automatic push_write(input reg_idx_t rd, input logic [`XLEN-1:0] value);
    if (rd != '0) exp_q.push_back(make_evt(EV_WRITE, rd, value));
  endtask

  // ------------------------------
  // Driver
  // ------------------------------

  task automatic apply_reset();
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    cdb_valid_i   = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    seen_q.delete();
    exp_q.delete();
  endtask

  function automatic reg_idx_t rand_rd();
    return reg_idx_t'(({$random(seed)} % 31) + 1);
  endfunction

  function automatic logic [`XLEN-1:0] rand_pc();
    logic [`XLEN-1:0] r;
    r = $random(seed);
    return {r[`XLEN-1:2], 2'b00};
  endfunction

  task automatic issue_instr(input logic [`XLEN-1:0] pc, input reg_idx_t rd,
                             output rob_idx_t idx);
    int cycles;
    cycles = 0;
    while (!issue_ready_o) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("timeout: the ROB never accepted an allocation");
        $display("sim failed");
        $fatal(1, "allocation stalled");
      end else begin
        @(negedge clk_i);
        cycles++;
      end
    end
    issue_valid_i        = 1'b1;
    issue_entry_i.pc     = pc;
    issue_entry_i.rd_idx = rd;
    idx                  = issue_tail_idx_o;
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic write_result(input rob_idx_t idx, input logic [`XLEN-1:0] value,
                              input logic exc, input except_code_t code, input logic mis);
    cdb_valid_i            = 1'b1;
    cdb_data_i.rob_idx     = idx;
    cdb_data_i.value       = value;
    cdb_data_i.except      = exc;
    cdb_data_i.except_code = code;
    cdb_data_i.mispredict  = mis;
    @(negedge clk_i);
    cdb_valid_i = 1'b0;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic reset_state();
    apply_reset();
    check_value("issue_ready_o", issue_ready_o, 1);
    check_value("issue_tail_idx_o", issue_tail_idx_o, 0);
    repeat (QUIET_CYCLES) @(negedge clk_i);
    check_value("retire event count", seen_q.size(), 0);
  endtask

  // Third instruction targets x0
  task automatic in_order_retire();
    rob_idx_t         idx[5];
    reg_idx_t         rd[5];
    logic [`XLEN-1:0] val[5];
    apply_reset();
    for (int i = 0; i < 5; i++) begin
      rd[i]  = (i == 2) ? '0 : rand_rd();
      val[i] = $random(seed);
      issue_instr(rand_pc(), rd[i], idx[i]);
      push_write(rd[i], val[i]);
    end
    for (int i = 4; i >= 0; i--) write_result(idx[i], val[i], 1'b0, '0, 1'b0);
    wait_retirements(exp_q.size());
    match_events();
  endtask

  task automatic full_rob();
    rob_idx_t         idx[`ROB_DEPTH];
    logic [`XLEN-1:0] val[`ROB_DEPTH];
    int               k;
    apply_reset();
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      val[i] = $random(seed);
      issue_instr(rand_pc(), reg_idx_t'(i + 1), idx[i]);
      check_value("issue_tail_idx_o", idx[i], i);
      push_write(reg_idx_t'(i + 1), val[i]);
    end
    check_value("issue_ready_o", issue_ready_o, 0);
    // Scrambled completion order
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      k = (i * 5 + 3) % `ROB_DEPTH;
      write_result(idx[k], val[k], 1'b0, '0, 1'b0);
    end
    wait_retirements(exp_q.size());
    match_events();
    check_value("issue_ready_o", issue_ready_o, 1);
  endtask

  task automatic trap_redirect(input logic [1:0] mode);
    rob_idx_t         idx[3];
    reg_idx_t         rd[3];
    logic [`XLEN-1:0] val[3];
    logic [`XLEN-1:0] r;
    except_code_t     code;
    logic [`XLEN-1:0] target;
    apply_reset();
    r                = $random(seed);
    csr_mtvec_i.base = r[`XLEN-1:2];
    csr_mtvec_i.mode = mode;
    code             = except_code_t'({$random(seed)});
    for (int i = 0; i < 3; i++) begin
      rd[i]  = rand_rd();
      val[i] = $random(seed);
      issue_instr(rand_pc(), rd[i], idx[i]);
    end
    target = `XLEN'(csr_mtvec_i.base) * 4;
    if (mode == 2'd1) target = target + `XLEN'(code) * 4;
    push_write(rd[0], val[0]);
    exp_q.push_back(make_evt(EV_TRAP, '0, target));
    write_result(idx[2], val[2], 1'b0, '0, 1'b0);
    write_result(idx[1], val[1], 1'b1, code, 1'b0);
    write_result(idx[0], val[0], 1'b0, '0, 1'b0);
    wait_retirements(exp_q.size());
    match_events();
    check_value("issue_tail_idx_o", issue_tail_idx_o, 0);
  endtask

  // Second instruction is the mispredicted branch
  task automatic mispredict_flush();
    rob_idx_t         idx[3];
    reg_idx_t         rd[3];
    logic [`XLEN-1:0] val[3];
    apply_reset();
    for (int i = 0; i < 3; i++) begin
      rd[i]  = rand_rd();
      val[i] = $random(seed);
      issue_instr(rand_pc(), rd[i], idx[i]);
    end
    push_write(rd[0], val[0]);
    push_write(rd[1], val[1]);
    exp_q.push_back(make_evt(EV_MIS, '0, '0));
    write_result(idx[2], val[2], 1'b0, '0, 1'b0);
    write_result(idx[1], val[1], 1'b0, '0, 1'b1);
    write_result(idx[0], val[0], 1'b0, '0, 1'b0);
    wait_retirements(exp_q.size());
    match_events();
    check_value("issue_tail_idx_o", issue_tail_idx_o, 0);
  endtask

  // Runs straight after the mispredict flush without a reset
  task automatic restart_after_flush();
    rob_idx_t         idx[3];
    reg_idx_t         rd[3];
    logic [`XLEN-1:0] val[3];
    seen_q.delete();
    exp_q.delete();
    for (int i = 0; i < 3; i++) begin
      rd[i]  = rand_rd();
      val[i] = $random(seed);
      issue_instr(rand_pc(), rd[i], idx[i]);
      check_value("issue_tail_idx_o", idx[i], i);
      push_write(rd[i], val[i]);
    end
    write_result(idx[2], val[2], 1'b0, '0, 1'b0);
    write_result(idx[0], val[0], 1'b0, '0, 1'b0);
    write_result(idx[1], val[1], 1'b0, '0, 1'b0);
    wait_retirements(exp_q.size());
    match_events();
  endtask

  initial begin
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_entry_i = '0;
    cdb_valid_i   = 1'b0;
    cdb_data_i    = '0;
    csr_mtvec_i   = '0;
    reset_state();
    in_order_retire();
    full_rob();
    trap_redirect(2'd0);
    trap_redirect(2'd1);
    mispredict_flush();
    restart_after_flush();
    $display("sim passed");
    $finish;
  end

endmodule
